// ==== rtl/aftabExecutePkg.sv ====
// ********************
// execute slice shared definitions
// widths, select codes and the instruction word views
// ********************

package aftabExecutePkg;

    // widths
    localparam int xlenDefault   = 32;
    localparam int instrWidth    = 32;
    localparam int regIndexWidth = 5;

    // immediate format
    localparam logic [1:0] immSelI = 2'd0;
    localparam logic [1:0] immSelS = 2'd1;
    localparam logic [1:0] immSelU = 2'd2;

    // logic unit operation
    localparam logic [1:0] logicAnd = 2'd0;
    localparam logic [1:0] logicOr  = 2'd1;
    localparam logic [1:0] logicXor = 2'd2;

    // barrel shifter direction and fill
    localparam logic [1:0] shiftLeft         = 2'd0;
    localparam logic [1:0] shiftRightLogical = 2'd1;
    localparam logic [1:0] shiftRightArith   = 2'd2;

    // write-back source
    localparam logic [1:0] resultArith = 2'd0;
    localparam logic [1:0] resultLogic = 2'd1;
    localparam logic [1:0] resultShift = 2'd2;
    localparam logic [1:0] resultImm   = 2'd3;

    // one instruction word seen as I/U layout or as S layout
    typedef union packed {
        struct packed {
            logic [11:0] immHigh;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iView;
        struct packed {
            logic [6:0] immUpper;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLower;
            logic [6:0] opcode;
        } sView;
    } instrWord_u;

endpackage

// ==== rtl/instructionDecode.sv ====
// ********************
// instruction register and immediate generator
// for the I, S and U formats
// ********************
`timescale 1ns/1ps

module instructionDecode #(
    parameter int xlen = 32
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    ldIR,
    input  logic [aftabExecutePkg::instrWidth-1:0]  instrIn,
    input  logic [1:0]                              immSel,
    output logic [aftabExecutePkg::regIndexWidth-1:0] rs1Index,
    output logic [aftabExecutePkg::regIndexWidth-1:0] rs2Index,
    output logic [aftabExecutePkg::regIndexWidth-1:0] rdIndex,
    output logic [xlen-1:0]                         immediate
);

    aftabExecutePkg::instrWord_u instrReg;

    logic signed [11:0] immI;
    logic signed [11:0] immS;
    logic signed [31:0] immU;

    // instruction register
    always_ff @(posedge clk) begin
        if (reset) begin
            instrReg <= '0;
        end else if (ldIR) begin
            instrReg <= instrIn;
        end
    end

    // register indices through the matching view
    assign rs1Index = instrReg.iView.rs1;
    assign rs2Index = instrReg.sView.rs2;
    assign rdIndex  = instrReg.iView.rd;

    // ********************
    // immediate formats
    // ********************
    assign immI = instrReg.iView.immHigh;
    assign immS = {instrReg.sView.immUpper, instrReg.sView.immLower};
    // upper twenty bits, low twelve cleared
    assign immU = {instrReg.iView.immHigh, instrReg.iView.rs1, instrReg.iView.funct3, 12'b0};

    // signed casts extend from the format's top bit
    always_comb begin
        case (immSel)
            aftabExecutePkg::immSelI: immediate = xlen'(immI);
            aftabExecutePkg::immSelS: immediate = xlen'(immS);
            aftabExecutePkg::immSelU: immediate = xlen'(immU);
            default:                  immediate = '0;
        endcase
    end

endmodule

// ==== rtl/registerBank.sv ====
// ********************
// register file, second operand mux and write-back select
// ********************
`timescale 1ns/1ps

module registerBank #(
    parameter int xlen = 32
) (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      writeRegFile,
    input  logic                                      selImm,
    input  logic [aftabExecutePkg::regIndexWidth-1:0] rs1Index,
    input  logic [aftabExecutePkg::regIndexWidth-1:0] rs2Index,
    input  logic [aftabExecutePkg::regIndexWidth-1:0] rdIndex,
    input  logic [xlen-1:0]                           immediate,
    input  logic [xlen-1:0]                           arithResult,
    input  logic [xlen-1:0]                           logicResult,
    input  logic [xlen-1:0]                           shiftResult,
    input  logic [1:0]                                resultSel,
    output logic [xlen-1:0]                           operandA,
    output logic [xlen-1:0]                           operandB,
    output logic [xlen-1:0]                           writeData
);

    localparam int numRegs = 1 << aftabExecutePkg::regIndexWidth;

    // x0 has no storage
    logic [xlen-1:0] regFile [1:numRegs-1];

    logic [xlen-1:0] readPort2;
    logic            writeEnable;

    // ********************
    // write port
    // ********************
    assign writeEnable = writeRegFile && (rdIndex != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < numRegs; i++) begin
                regFile[i] <= '0;
            end
        end else if (writeEnable) begin
            regFile[rdIndex] <= writeData;
        end
    end

    // ********************
    // read ports
    // ********************
    // index zero reads as zero
    assign operandA  = (rs1Index == '0) ? '0 : regFile[rs1Index];
    assign readPort2 = (rs2Index == '0) ? '0 : regFile[rs2Index];

    // register or immediate as second operand
    assign operandB = selImm ? immediate : readPort2;

    // write-back source
    always_comb begin
        case (resultSel)
            aftabExecutePkg::resultArith: writeData = arithResult;
            aftabExecutePkg::resultLogic: writeData = logicResult;
            aftabExecutePkg::resultShift: writeData = shiftResult;
            aftabExecutePkg::resultImm:   writeData = immediate;
            default:                      writeData = '0;
        endcase
    end

endmodule

// ==== rtl/arithmeticUnit.sv ====
// ********************
// adder/subtractor and signed/unsigned comparator
// ********************
`timescale 1ns/1ps

module arithmeticUnit #(
    parameter int xlen = 32
) (
    input  logic [xlen-1:0] operandA,
    input  logic [xlen-1:0] operandB,
    input  logic            addSubBar,
    input  logic            compareSigned,
    output logic [xlen-1:0] arithResult,
    output logic            lt,
    output logic            eq,
    output logic            gt
);

    logic [xlen-1:0] operandBMod;

    // subtract as a + ~b + 1
    assign operandBMod = operandB ^ {xlen{addSubBar}};
    assign arithResult = operandA + operandBMod + xlen'(addSubBar);

    // ********************
    // comparator
    // ********************
    assign eq = (operandA == operandB);

    // less and greater in the same compare mode
    always_comb begin
        if (compareSigned) begin
            lt = $signed(operandA) < $signed(operandB);
            gt = $signed(operandA) > $signed(operandB);
        end else begin
            lt = operandA < operandB;
            gt = operandA > operandB;
        end
    end

endmodule

// ==== rtl/logicShiftUnit.sv ====
// ********************
// and/or/xor logic unit and barrel shifter
// ********************
`timescale 1ns/1ps

module logicShiftUnit #(
    parameter int xlen = 32
) (
    input  logic [xlen-1:0] operandA,
    input  logic [xlen-1:0] operandB,
    input  logic [1:0]      selLogic,
    input  logic [1:0]      selShift,
    output logic [xlen-1:0] logicResult,
    output logic [xlen-1:0] shiftResult
);

    // five bits at 32, six at 64
    localparam int shamtWidth = $clog2(xlen);

    logic [shamtWidth-1:0] shiftAmount;
    logic [xlen-1:0]       stageVal;

    // logic unit
    always_comb begin
        case (selLogic)
            aftabExecutePkg::logicAnd: logicResult = operandA & operandB;
            aftabExecutePkg::logicOr:  logicResult = operandA | operandB;
            aftabExecutePkg::logicXor: logicResult = operandA ^ operandB;
            default:                   logicResult = '0;
        endcase
    end

    // ********************
    // barrel shifter
    // ********************
    assign shiftAmount = operandB[shamtWidth-1:0];

    // stage s moves by 2**s positions
    always_comb begin
        stageVal = operandA;
        for (int s = 0; s < shamtWidth; s++) begin
            if (shiftAmount[s]) begin
                case (selShift)
                    aftabExecutePkg::shiftLeft:         stageVal = stageVal << (1 << s);
                    aftabExecutePkg::shiftRightLogical: stageVal = stageVal >> (1 << s);
                    aftabExecutePkg::shiftRightArith:   stageVal = $signed(stageVal) >>> (1 << s);
                    default:                            stageVal = stageVal;
                endcase
            end
        end
    end

    assign shiftResult = stageVal;

endmodule

// ==== rtl/aftabExecute.sv ====
// ********************
// integer execute engine
// decode, operands, arithmetic and logic/shift side by side
// ********************
`timescale 1ns/1ps

module aftabExecute #(
    parameter int xlen = aftabExecutePkg::xlenDefault
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   ldIR,
    input  logic                                   writeRegFile,
    input  logic                                   selImm,
    input  logic                                   addSubBar,
    input  logic                                   compareSigned,
    input  logic [aftabExecutePkg::instrWidth-1:0] instrIn,
    input  logic [1:0]                             immSel,
    input  logic [1:0]                             selLogic,
    input  logic [1:0]                             selShift,
    input  logic [1:0]                             resultSel,
    output logic [xlen-1:0]                        writeData,
    output logic                                   lt,
    output logic                                   eq,
    output logic                                   gt
);

    logic [aftabExecutePkg::regIndexWidth-1:0] rs1Index;
    logic [aftabExecutePkg::regIndexWidth-1:0] rs2Index;
    logic [aftabExecutePkg::regIndexWidth-1:0] rdIndex;
    logic [xlen-1:0] immediate;
    logic [xlen-1:0] operandA;
    logic [xlen-1:0] operandB;
    logic [xlen-1:0] arithResult;
    logic [xlen-1:0] logicResult;
    logic [xlen-1:0] shiftResult;

    instructionDecode #(.xlen(xlen)) u_decode (
        .clk      (clk),
        .reset    (reset),
        .ldIR     (ldIR),
        .instrIn  (instrIn),
        .immSel   (immSel),
        .rs1Index (rs1Index),
        .rs2Index (rs2Index),
        .rdIndex  (rdIndex),
        .immediate(immediate)
    );

    registerBank #(.xlen(xlen)) u_regBank (
        .clk         (clk),
        .reset       (reset),
        .writeRegFile(writeRegFile),
        .selImm      (selImm),
        .rs1Index    (rs1Index),
        .rs2Index    (rs2Index),
        .rdIndex     (rdIndex),
        .immediate   (immediate),
        .arithResult (arithResult),
        .logicResult (logicResult),
        .shiftResult (shiftResult),
        .resultSel   (resultSel),
        .operandA    (operandA),
        .operandB    (operandB),
        .writeData   (writeData)
    );

    // both units see the same operands
    arithmeticUnit #(.xlen(xlen)) u_arith (
        .operandA     (operandA),
        .operandB     (operandB),
        .addSubBar    (addSubBar),
        .compareSigned(compareSigned),
        .arithResult  (arithResult),
        .lt           (lt),
        .eq           (eq),
        .gt           (gt)
    );

    logicShiftUnit #(.xlen(xlen)) u_logicShift (
        .operandA   (operandA),
        .operandB   (operandB),
        .selLogic   (selLogic),
        .selShift   (selShift),
        .logicResult(logicResult),
        .shiftResult(shiftResult)
    );

endmodule

// ==== bench/aftabExecute_chk.sv ====
// ********************
// concurrent checks on the execute engine outputs
// ********************
`timescale 1ns/1ps

module aftabExecute_chk #(
    parameter int xlen = 32
) (
    input logic            clk,
    input logic            reset,
    input logic            lt,
    input logic            eq,
    input logic            gt,
    input logic [xlen-1:0] operandA,
    input logic [xlen-1:0] operandB,
    input logic [xlen-1:0] arithResult,
    input logic [xlen-1:0] writeData,
    input logic [1:0]      resultSel
);

    flagsOneHot: assert property (@(posedge clk) disable iff (reset) $onehot({lt, eq, gt}))
        else $error("compare flags are not one-hot");

    eqOnEqual: assert property (@(posedge clk) disable iff (reset) (operandA == operandB) |-> eq)
        else $error("eq low although operands are equal");

    // arithmetic write-back path
    arithSelected: assert property (@(posedge clk) disable iff (reset)
        (resultSel == aftabExecutePkg::resultArith) |-> (writeData == arithResult))
        else $error("writeData differs from arithResult under resultArith");

endmodule

bind aftabExecute aftabExecute_chk #(.xlen(xlen)) u_chk (
    .clk(clk), .reset(reset), .lt(lt), .eq(eq), .gt(gt),
    .operandA(operandA), .operandB(operandB), .arithResult(arithResult),
    .writeData(writeData), .resultSel(resultSel)
);

// ==== bench/aftabExecuteTb.sv ====
// ********************
// execute engine testbench
// table driven rows checked against a shadow register model
// ********************
`timescale 1ns/1ps

module aftabExecuteTb;

    localparam int clkPeriod = 100;
    localparam int maxRows   = 96;

    logic        clk, reset, ldIR, writeRegFile, selImm, addSubBar, compareSigned;
    logic [31:0] instrIn;
    logic [1:0]  immSel, selLogic, selShift, resultSel;
    logic [31:0] writeData;
    logic        lt, eq, gt;

    // stimulus table of instruction, packed controls and expected outputs
    logic [31:0] tabInstr [maxRows];
    logic [11:0] tabCtrl  [maxRows];
    logic [31:0] tabWd    [maxRows];
    logic [2:0]  tabFlags [maxRows];
    int          rowCount;
    int          errorCount;
    logic [31:0] shadowRegs [32];
    logic [31:0] lfsrState;
    logic [31:0] valA, amount;

    aftabExecute u_dut (
        .clk(clk), .reset(reset), .ldIR(ldIR), .writeRegFile(writeRegFile),
        .selImm(selImm), .addSubBar(addSubBar), .compareSigned(compareSigned),
        .instrIn(instrIn), .immSel(immSel), .selLogic(selLogic), .selShift(selShift),
        .resultSel(resultSel), .writeData(writeData), .lt(lt), .eq(eq), .gt(gt)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // fibonacci lfsr with taps 32 22 2 1
    // one step per bit taken
    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = {lfsrState[30:0],
                         lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] iInstr(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [4:0] rd);
        return {imm, rs1, 3'b000, rd, 7'h13};
    endfunction

    function automatic logic [31:0] sInstr(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] rInstr(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [4:0] rd);
        return {7'h00, rs2, rs1, 3'b000, rd, 7'h33};
    endfunction

    // reference model run while the table is built
    task automatic addRow(input logic [31:0] instr, input logic [1:0] iSel, input logic sImm,
                          input logic sub, input logic sgn, input logic [1:0] lSel,
                          input logic [1:0] shSel, input logic [1:0] rSel, input logic wr);
        logic [31:0] imm, a, b, res;
        logic        less;
        logic        greater;
        case (iSel)
            aftabExecutePkg::immSelI: imm = {{20{instr[31]}}, instr[31:20]};
            aftabExecutePkg::immSelS: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            aftabExecutePkg::immSelU: imm = {instr[31:12], 12'h000};
            default:                  imm = '0;
        endcase
        a = shadowRegs[instr[19:15]];
        b = sImm ? imm : shadowRegs[instr[24:20]];
        less    = sgn ? ($signed(a) < $signed(b)) : (a < b);
        greater = sgn ? ($signed(a) > $signed(b)) : (a > b);
        case (rSel)
            aftabExecutePkg::resultArith: res = sub ? a - b : a + b;
            aftabExecutePkg::resultLogic:
                res = (lSel == aftabExecutePkg::logicAnd) ? (a & b) :
                      (lSel == aftabExecutePkg::logicOr)  ? (a | b) :
                      (lSel == aftabExecutePkg::logicXor) ? (a ^ b) : '0;
            aftabExecutePkg::resultShift:
                res = (shSel == aftabExecutePkg::shiftLeft)         ? (a << b[4:0]) :
                      (shSel == aftabExecutePkg::shiftRightLogical) ? (a >> b[4:0]) :
                      (shSel == aftabExecutePkg::shiftRightArith)
                          ? 32'($signed(a) >>> b[4:0]) : a;
            default: res = imm;
        endcase
        tabInstr[rowCount] = instr;
        tabCtrl[rowCount]  = {iSel, sImm, sub, sgn, lSel, shSel, rSel, wr};
        tabWd[rowCount]    = res;
        tabFlags[rowCount] = {less, a == b, greater};
        rowCount++;
        if (wr && instr[11:7] != 5'd0) begin
            shadowRegs[instr[11:7]] = res;
        end
    endtask

    // upper part through a U row and low twelve bits through an I row
    task automatic loadValue(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = (value + 32'h800) >> 12;
        addRow({upper[19:0], rd, 7'h37}, aftabExecutePkg::immSelU, 1'b1, 1'b0, 1'b0,
               2'd0, 2'd0, aftabExecutePkg::resultImm, 1'b1);
        addRow(iInstr(value[11:0], rd, rd), aftabExecutePkg::immSelI, 1'b1, 1'b0, 1'b0,
               2'd0, 2'd0, aftabExecutePkg::resultArith, 1'b1);
    endtask

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            errorCount++;
            failRun($sformatf("Error: %s is 0x%h, expected 0x%h", name, actual, expected));
        end
    endtask

    // one clock edge bounded by two periods
    task automatic waitEdge(input logic rising);
        logic seen;
        seen = 1'b0;
        fork
            begin
                if (rising) @(posedge clk);
                else @(negedge clk);
                seen = 1'b1;
            end
            begin
                #(2 * clkPeriod);
            end
        join_any
        disable fork;
        if (!seen) begin
            failRun("the clock stopped, no edge arrived within two periods");
        end
    endtask

    initial begin
        reset = 1'b1;
        ldIR = 1'b0;
        writeRegFile = 1'b0;
        selImm = 1'b0;
        addSubBar = 1'b0;
        compareSigned = 1'b0;
        instrIn = '0;
        immSel = '0;
        selLogic = '0;
        selShift = '0;
        resultSel = '0;
        rowCount = 0;
        errorCount = 0;
        lfsrState = 32'h0b7f7e78;
        for (int i = 0; i < 32; i++) begin
            shadowRegs[i] = '0;
        end

        // ********************
        // table build
        // ********************
        loadValue(5'd1, randomBits(32));
        loadValue(5'd2, randomBits(32));
        loadValue(5'd3, 32'h8000_0001);
        loadValue(5'd4, 32'h0000_0005);
        loadValue(5'd0, 32'hdead_beef);
        addRow(rInstr(5'd0, 5'd1, 5'd7), 2'd0, 1'b0, 1'b0, 1'b0, 2'd0, 2'd0,
               aftabExecutePkg::resultArith, 1'b1);
        addRow(rInstr(5'd0, 5'd0, 5'd6), 2'd0, 1'b0, 1'b0, 1'b0, 2'd0, 2'd0,
               aftabExecutePkg::resultArith, 1'b1);
        for (int sub = 0; sub < 2; sub++) begin
            addRow(rInstr(5'd2, 5'd1, 5'd8), 2'd0, 1'b0, sub[0], 1'b0, 2'd0, 2'd0,
                   aftabExecutePkg::resultArith, 1'b1);
            addRow(iInstr(12'hf85, 5'd8, 5'd9), aftabExecutePkg::immSelI, 1'b1, sub[0],
                   1'b0, 2'd0, 2'd0, aftabExecutePkg::resultArith, 1'b1);
            addRow(sInstr(12'h9a3, 5'd5, 5'd2), aftabExecutePkg::immSelS, 1'b1, sub[0],
                   1'b0, 2'd0, 2'd0, aftabExecutePkg::resultArith, 1'b0);
        end
        // top bits differ so signed and unsigned disagree
        for (int sgn = 0; sgn < 2; sgn++) begin
            addRow(rInstr(5'd4, 5'd3, 5'd0), 2'd0, 1'b0, 1'b1, sgn[0], 2'd0, 2'd0,
                   aftabExecutePkg::resultArith, 1'b0);
            addRow(rInstr(5'd3, 5'd4, 5'd0), 2'd0, 1'b0, 1'b1, sgn[0], 2'd0, 2'd0,
                   aftabExecutePkg::resultArith, 1'b0);
        end
        for (int op = 0; op < 3; op++) begin
            addRow(rInstr(5'd2, 5'd1, 5'd0), 2'd0, 1'b0, 1'b0, 1'b0, op[1:0], 2'd0,
                   aftabExecutePkg::resultLogic, 1'b0);
            for (int k = 0; k < 5; k++) begin
                amount = (k == 0) ? 32'd0 : (k == 1) ? 32'd1 : (k == 2) ? 32'd31
                                                               : randomBits(5);
                valA = {27'd0, amount[4:0]};
                addRow(iInstr(valA[11:0], 5'd1, 5'd0), aftabExecutePkg::immSelI, 1'b1,
                       1'b0, 1'b0, 2'd0, op[1:0], aftabExecutePkg::resultShift, 1'b0);
                addRow(iInstr(valA[11:0], 5'd3, 5'd0), aftabExecutePkg::immSelI, 1'b1,
                       1'b0, 1'b0, 2'd0, op[1:0], aftabExecutePkg::resultShift, 1'b0);
            end
        end

        // ********************
        // reset and run
        // ********************
        for (int c = 0; c < 16; c++) begin
            waitEdge(1'b1);
        end
        reset <= 1'b0;
        waitEdge(1'b0);
        compareValue("writeData", writeData, 32'h0);
        compareValue("flags", {29'd0, lt, eq, gt}, 32'h2);
        waitEdge(1'b1);

        for (int r = 0; r < rowCount; r++) begin
            instrIn <= tabInstr[r];
            {immSel, selImm, addSubBar, compareSigned, selLogic, selShift, resultSel} <=
                tabCtrl[r][11:1];
            ldIR <= 1'b1;
            writeRegFile <= 1'b0;
            waitEdge(1'b1);
            ldIR <= 1'b0;
            writeRegFile <= tabCtrl[r][0];
            waitEdge(1'b0);
            compareValue("writeData", writeData, tabWd[r]);
            compareValue("lt,eq,gt", {29'd0, lt, eq, gt}, {29'd0, tabFlags[r]});
            waitEdge(1'b1);
        end
        writeRegFile <= 1'b0;
        waitEdge(1'b1);

        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== files.f ====
rtl/aftabExecutePkg.sv
rtl/instructionDecode.sv
rtl/registerBank.sv
rtl/arithmeticUnit.sv
rtl/logicShiftUnit.sv
rtl/aftabExecute.sv
bench/aftabExecute_chk.sv
bench/aftabExecuteTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the execute slice testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f files.f \
    --top-module aftabExecuteTb \
    -o aftabExecuteSim

./obj_dir/aftabExecuteSim | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    exit 0
else
    exit 1
fi
